//--- compile.f
logic/imdct_pkg.sv
logic/imdct_sum_if.sv
logic/imdct_cos_rom.sv
logic/imdct_long_mac.sv
logic/imdct_sum_fifo.sv
logic/imdct_mirror_out.sv
logic/imdct_long_top.sv
verification/imdct_long_tb.sv

//--- logic/imdct_cos_quarter.hex
// one 18-bit Q2.16 word per line: cos(pi*i/72) for i = 0 to 36
10000
0FFC2
0FF07
0FDCF
0FC1C
0F9EF
0F747
0F427
0F090
0EC83
0E804
0E313
0DDB4
0D7E9
0D1B4
0CB19
0C41B
0BCBE
0B505
0ACF3
0A48E
09BD8
092D6
0898C
08000
07635
06C31
061F8
0578F
04CFB
04242
03769
02C74
0216A
01650
00B2B
00000

//--- verification/imdct_long_tb.sv
`timescale 1ns/1ns

module imdct_long_tb import imdct_pkg::*; ();

    logic                clk;
    logic                rst;
    logic                start;
    logic [addr_w-1:0]   base_addr;
    logic [sample_w-1:0] read_data;
    logic                out_ready;
    logic [addr_w-1:0]   read_addr;
    logic                out_valid;
    logic [sample_w-1:0] value_0;
    logic [sample_w-1:0] value_1;
    logic [index_w-1:0]  index_0;
    logic [index_w-1:0]  index_1;
    logic                band_done;

    logic [sample_w-1:0] sample_mem [1024];
    logic [sample_w-1:0] cos_q [quarter_len];
    logic [47:0]         expected_q [$]; // {index_0, value_0, index_1, value_1}
    integer              seed;
    int                  err_count;
    int                  test_count;
    int                  fail_count;
    bit                  timed_out;

    imdct_long_top imdct_long_top_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .base_addr (base_addr),
        .read_data (read_data),
        .out_ready (out_ready),
        .read_addr (read_addr),
        .out_valid (out_valid),
        .value_0   (value_0),
        .value_1   (value_1),
        .index_0   (index_0),
        .index_1   (index_1),
        .band_done (band_done)
    );

    assign read_data = sample_mem[read_addr]; // combinational sample memory

    always #50 clk = ~clk;

    function automatic logic [17:0] model_coef(input int n, input int k);
        int p;
        p = ((2 * n + 19) * (2 * k + 1)) % 144;
        if (p <= 36) return cos_q[p];
        else if (p <= 72) return 18'd0 - cos_q[72 - p];
        else if (p <= 108) return 18'd0 - cos_q[p - 72];
        else return cos_q[144 - p];
    endfunction

    function automatic logic [17:0] model_product(input logic [17:0] s, input logic [17:0] c);
        longint full;
        longint shifted;
        full    = longint'($signed(s)) * longint'($signed(c));
        shifted = full >>> 16;
        return shifted[17:0];
    endfunction

    task automatic build_expected(input logic [addr_w-1:0] base);
        logic [17:0] sum;
        logic [17:0] v1;
        logic [5:0]  i1;
        for (int n = 9; n <= 26; n++) begin
            sum = '0;
            for (int k = 0; k < 18; k++) begin
                sum = sum + model_product(sample_mem[addr_w'(base + k)], model_coef(n, k));
            end
            if (n < 18) begin
                i1 = 6'(17 - n);
                v1 = 18'd0 - sum; // lower half mirrors with a sign flip
            end else begin
                i1 = 6'(53 - n);
                v1 = sum;
            end
            expected_q.push_back({6'(n), sum, i1, v1});
        end
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [17:0] expected, input logic [17:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic run_band(input string name, input int ready_odds, input bit second_start);
        logic [addr_w-1:0] base;
        logic [47:0]       got;
        logic [47:0]       prev_word;
        logic [47:0]       exp_word;
        bit                prev_valid;
        bit                prev_ready;
        bit                done_seen;
        int                pairs;
        int                acc_cycles;
        int                cycles;
        int                errs_before;
        errs_before = err_count;
        base        = addr_w'(1 + ({$random(seed)} % 1000)); // keeps base..base+17 off zero
        cycles      = 0;
        while (band_done !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (band_done !== 1'b1) begin
            $display("%s: band_done never came high before the start pulse", name);
            err_count++;
            timed_out = 1;
            finish_test(name, errs_before);
            return;
        end
        build_expected(base);
        prev_valid = 0;
        prev_ready = 0;
        prev_word  = '0;
        done_seen  = 0;
        pairs      = 0;
        acc_cycles = 0;
        cycles     = 0;
        start      = 1'b1;
        base_addr  = base;
        @(negedge clk);
        start = 1'b0;
        if (band_done !== 1'b0) begin
            $display("%s: band_done stayed high after an accepted start", name);
            err_count++;
        end
        while (!(pairs == 18 && band_done === 1'b1) && cycles < 4000) begin
            got = {index_0, value_0, index_1, value_1};
            if (read_addr != '0) begin
                acc_cycles++;
                if (read_addr < base || read_addr > base + 17) begin
                    $display("ERR %s read_addr expected %0d..%0d actual %0d",
                             name, base, base + 17, read_addr);
                    err_count++;
                end
            end
            if (band_done === 1'b1 && !done_seen) begin
                done_seen = 1;
                check_value(name, "accumulate_cycles", 18'd324, 18'(acc_cycles));
            end else if (band_done !== 1'b1 && done_seen) begin
                $display("%s: band_done fell again without an accepted start", name);
                err_count++;
            end
            if (prev_valid && !prev_ready && (out_valid !== 1'b1 || got !== prev_word)) begin
                $display("%s: output pair changed while out_ready was low", name);
                err_count++;
            end
            start     = second_start && cycles == 40; // lands mid-band and must be ignored
            base_addr = base ^ 10'h155;
            out_ready = ({$random(seed)} % ready_odds) == 0; // ready on one cycle in ready_odds
            if (out_valid === 1'b1 && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("%s: more output pairs arrived than the band holds", name);
                    err_count++;
                end else begin
                    exp_word = expected_q.pop_front();
                    check_value(name, "index_0", 18'(exp_word[47:42]), 18'(index_0));
                    check_value(name, "value_0", exp_word[41:24], value_0);
                    check_value(name, "index_1", 18'(exp_word[23:18]), 18'(index_1));
                    check_value(name, "value_1", exp_word[17:0], value_1);
                end
                pairs++;
            end
            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_word  = got;
            @(negedge clk);
            cycles++;
        end
        if (!(pairs == 18 && band_done === 1'b1)) begin
            $display("%s: timed out with %0d of 18 output pairs received", name, pairs);
            err_count++;
            timed_out = 1;
            finish_test(name, errs_before);
            return;
        end
        for (int i = 0; i < 3; i++) begin // the stage must stay quiet after the last pair
            if (out_valid !== 1'b0 || band_done !== 1'b1 || read_addr != '0) begin
                $display("%s: activity after the eighteenth pair was taken", name);
                err_count++;
            end
            @(negedge clk);
        end
        check_value(name, "accumulate_cycles", 18'd324, 18'(acc_cycles));
        expected_q.delete();
        finish_test(name, errs_before);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        base_addr  = '0;
        out_ready  = 1'b1;
        err_count  = 0;
        test_count = 0;
        fail_count = 0;
        timed_out  = 0;
        seed       = 32'h5526_9c3f;
        for (int a = 0; a < 1024; a++) begin
            sample_mem[a] = 18'($random(seed));
        end
        $readmemh("logic/imdct_cos_quarter.hex", cos_q);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset_state", "out_valid", 18'd0, 18'(out_valid));
        check_value("reset_state", "band_done", 18'd1, 18'(band_done));
        finish_test("reset_state", 0);
        run_band("single_band", 1, 0);
        for (int b = 0; b < 3 && !timed_out; b++) begin
            // later bands drain slower than sums arrive, so the buffer fills
            run_band($sformatf("random_ready_%0d", b), (b == 0) ? 2 : 32, 0);
        end
        if (!timed_out) begin
            run_band("ignored_start", 2, 1);
        end
        $display("tests run %0d, tests failed %0d, errors %0d", test_count, fail_count,
                 err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- logic/imdct_long_top.sv
`timescale 1ns/1ns

module imdct_long_top import imdct_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic [addr_w-1:0]   base_addr,
    input  logic [sample_w-1:0] read_data,
    input  logic                out_ready,
    output logic [addr_w-1:0]   read_addr,
    output logic                out_valid,
    output logic [sample_w-1:0] value_0,
    output logic [sample_w-1:0] value_1,
    output logic [index_w-1:0]  index_0,
    output logic [index_w-1:0]  index_1,
    output logic                band_done
);

    imdct_sum_if mac_to_fifo ();
    imdct_sum_if fifo_to_out ();

    imdct_long_mac imdct_long_mac_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .base_addr (base_addr),
        .read_data (read_data),
        .read_addr (read_addr),
        .band_done (band_done),
        .sum_out   (mac_to_fifo)
    );

    imdct_sum_fifo imdct_sum_fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .in_side  (mac_to_fifo),
        .out_side (fifo_to_out)
    );

    imdct_mirror_out imdct_mirror_out_inst (
        .clk       (clk),
        .rst       (rst),
        .sum_in    (fifo_to_out),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .value_0   (value_0),
        .index_0   (index_0),
        .value_1   (value_1),
        .index_1   (index_1)
    );

endmodule

//--- logic/imdct_mirror_out.sv
`timescale 1ns/1ns

module imdct_mirror_out import imdct_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    imdct_sum_if.sink           sum_in,
    input  logic                out_ready,
    output logic                out_valid,
    output logic [sample_w-1:0] value_0,
    output logic [index_w-1:0]  index_0,
    output logic [sample_w-1:0] value_1,
    output logic [index_w-1:0]  index_1
);

    logic load;

    assign sum_in.ready = !out_valid || out_ready; // stage empty or draining now
    assign load         = sum_in.valid & sum_in.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            index_0 <= sum_in.n;
            value_0 <= sum_in.sum;
            if (sum_in.n <= index_w'(mirror_low_base)) begin
                index_1 <= index_w'(mirror_low_base) - sum_in.n;
                value_1 <= ~sum_in.sum + 1'b1; // two's complement, zero stays zero
            end else begin
                index_1 <= index_w'(mirror_high_base) - sum_in.n;
                value_1 <= sum_in.sum;
            end
        end
    end

endmodule

//--- logic/imdct_sum_fifo.sv
`timescale 1ns/1ns

module imdct_sum_fifo import imdct_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    imdct_sum_if.sink   in_side,
    imdct_sum_if.source out_side
);

    logic [index_w-1:0]  n_mem   [fifo_depth];
    logic [sample_w-1:0] sum_mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;
    logic                  push;
    logic                  pop;

    assign in_side.ready  = (count != (fifo_ptr_w + 1)'(fifo_depth));
    assign out_side.valid = (count != '0);

    assign push = in_side.valid & in_side.ready;
    assign pop  = out_side.valid & out_side.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            n_mem[wr_ptr]   <= in_side.n;
            sum_mem[wr_ptr] <= in_side.sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign out_side.n   = n_mem[rd_ptr]; // head shows without a read request
    assign out_side.sum = sum_mem[rd_ptr];

endmodule

//--- logic/imdct_long_mac.sv
`timescale 1ns/1ns

module imdct_long_mac import imdct_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic [addr_w-1:0]   base_addr,
    input  logic [sample_w-1:0] read_data,
    output logic [addr_w-1:0]   read_addr,
    output logic                band_done,
    imdct_sum_if.source         sum_out
);

    logic [1:0]                   state;
    logic [index_w-1:0]           n;
    logic [k_w-1:0]               k;
    logic [addr_w-1:0]            base_q;
    logic [sample_w-1:0]          acc;
    logic [sample_w-1:0]          coef;
    logic signed [2*sample_w-1:0] prod_full;
    logic [sample_w-1:0]          product;

    imdct_cos_rom cos_rom_inst (
        .n    (n),
        .k    (k),
        .coef (coef)
    );

    assign prod_full = $signed(read_data) * $signed(coef);
    assign product   = prod_full[frac_w +: sample_w]; // >>> 16, then wrap to 18 bits

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mac_idle;
            n     <= index_w'(n_first);
            k     <= '0;
        end else begin
            case (state)
                mac_idle: begin
                    if (start) begin
                        state <= mac_acc;
                        n     <= index_w'(n_first);
                        k     <= '0;
                    end
                end
                mac_acc: begin
                    k <= k + 1'b1;
                    if (k == k_w'(taps - 1)) begin
                        state <= mac_emit;
                    end
                end
                mac_emit: begin
                    if (sum_out.ready) begin
                        k <= '0;
                        if (n == index_w'(n_last)) begin
                            state <= mac_idle;
                        end else begin
                            n     <= n + 1'b1;
                            state <= mac_acc;
                        end
                    end
                end
                default: state <= mac_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mac_idle && start) begin
            base_q <= base_addr;
            acc    <= '0;
        end else if (state == mac_acc) begin
            acc <= acc + product;
        end else if (state == mac_emit && sum_out.ready) begin
            acc <= '0; // fresh sum for next n
        end
    end

    assign read_addr = (state == mac_acc) ? base_q + addr_w'(k) : '0;
    assign band_done = (state == mac_idle);

    assign sum_out.valid = (state == mac_emit);
    assign sum_out.n     = n;
    assign sum_out.sum   = acc;

endmodule

//--- logic/imdct_cos_rom.sv
`timescale 1ns/1ns

module imdct_cos_rom import imdct_pkg::*; (
    input  logic [index_w-1:0]  n,
    input  logic [k_w-1:0]      k,
    output logic [sample_w-1:0] coef
);

    logic [sample_w-1:0] cos_table [quarter_len];
    logic [11:0]         phase_full;
    logic [7:0]          phase;
    logic [5:0]          tab_idx;
    logic                negate;

    initial begin
        $readmemh("logic/imdct_cos_quarter.hex", cos_table);
    end

    // (2n+19)(2k+1) peaks at 71*35, fits in 12 bits
    assign phase_full = (12'(n) * 12'd2 + 12'd19) * (12'(k) * 12'd2 + 12'd1);
    assign phase      = 8'(phase_full % 12'(phase_period));

    always_comb begin
        if (phase <= 8'(quarter_len - 1)) begin
            tab_idx = 6'(phase);
            negate  = 1'b0;
        end else if (phase <= 8'(phase_period / 2)) begin
            tab_idx = 6'(8'(phase_period / 2) - phase); // second quadrant
            negate  = 1'b1;
        end else if (phase <= 8'(phase_period / 2 + quarter_len - 1)) begin
            tab_idx = 6'(phase - 8'(phase_period / 2));
            negate  = 1'b1;
        end else begin
            tab_idx = 6'(8'(phase_period) - phase);
            negate  = 1'b0;
        end
    end

    assign coef = negate ? (~cos_table[tab_idx] + 1'b1) : cos_table[tab_idx];

endmodule

//--- logic/imdct_sum_if.sv
`timescale 1ns/1ns

interface imdct_sum_if import imdct_pkg::*; ();

    logic                valid;
    logic                ready;
    logic [index_w-1:0]  n;     // output position of this sum
    logic [sample_w-1:0] sum;

    modport source (
        output valid, n, sum,
        input  ready
    );

    modport sink (
        input  valid, n, sum,
        output ready
    );

endinterface

//--- logic/imdct_pkg.sv
package imdct_pkg;

    // fixed point format, Q2.16
    localparam int sample_w = 18;
    localparam int frac_w   = 16;

    localparam int addr_w  = 10;
    localparam int index_w = 6;
    localparam int k_w     = 5;

    localparam int taps    = 18; // samples per sum
    localparam int n_first = 9;
    localparam int n_last  = 26;

    localparam int mirror_low_base  = 17; // n < 18
    localparam int mirror_high_base = 53;

    localparam int phase_period = 144;
    localparam int quarter_len  = 37; // cos(pi*i/72), i = 0..36

    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

    localparam logic [1:0] mac_idle = 2'd0;
    localparam logic [1:0] mac_acc  = 2'd1;
    localparam logic [1:0] mac_emit = 2'd2;

endpackage
